//--- verif/flight_tests.txt
# count throttle yaw_t roll_t pitch_t yaw_r roll_r pitch_r | expected fl fr rl rr
# all hex; count is the number of control cycles run before the motors are checked
01 800 0000 0000 0000 0000 0000 0000 040 040 040 040
01 800 0000 0000 0000 0000 0000 0000 080 080 080 080
01 800 0000 0000 0000 0000 0000 0000 0c0 0c0 0c0 0c0
01 800 0000 0000 0000 0000 0000 0000 100 100 100 100
01 120 0000 0000 0000 0000 0000 0000 120 120 120 120
01 120 0000 0280 0000 0000 0000 0000 153 0ed 153 0ed
01 120 0000 0280 0000 0000 0000 0000 154 0ec 154 0ec
01 120 0000 0280 0000 0000 0000 0000 155 0eb 155 0eb
01 120 0000 0000 0000 0000 0280 0000 0f0 150 0f0 150
01 120 0000 0000 0000 0000 0280 0000 0ef 151 0ef 151
01 120 0000 0000 0000 0000 0280 0000 0ee 152 0ee 152
01 120 00a0 00a0 0000 00a0 00a0 0000 111 12f 12f 111
01 120 ff60 ff60 0000 ff60 ff60 0000 12f 111 111 12f
01 120 0000 0000 00a0 0000 0000 00a0 139 139 107 107
01 120 0000 0000 ff60 0000 0000 ff60 107 107 139 139
01 120 0000 7000 7000 0000 9000 7000 314 120 120 000
38 f00 0000 0000 0000 0000 0000 0000 f7e f00 f00 e82
01 f00 0000 7000 7000 0000 9000 7000 fff f00 f00 d0c
01 f00 0000 7000 7000 0000 9000 7000 fff f00 f00 d0c
01 f00 0000 0000 0000 0000 0000 0000 fff f00 f00 e00

//--- flight_control_core.f
hdl/flight_pkg.sv
hdl/pid.sv
hdl/body_frame_controller.sv
hdl/throttle_ramp.sv
hdl/motor_mixer.sv
hdl/flight_control_core.sv
verif/flight_control_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0 -Wno-fatal
TOP ?= flight_control_core_tb
FILELIST ?= flight_control_core.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG = Verification passed

SOURCES = $(wildcard hdl/*.sv) $(wildcard verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/flight_control_core_tb.sv
/* File-driven testbench for flight_control_core. Run from the project root,
   vectors are read from verif/flight_tests.txt and checked after each mix. */
`timescale 1ns/1ns

module flight_control_core_tb;

	localparam int CLK_PERIOD = 20;
	localparam int MIX_TIMEOUT = 50;

	logic us_clk;
	logic resetn;
	logic start_signal;
	flight_pkg::throttle_t throttle_cmd;
	flight_pkg::rate_t yaw_target, roll_target, pitch_target;
	flight_pkg::rate_t yaw_rotation, roll_rotation, pitch_rotation;
	flight_pkg::motor_t motor_fl, motor_fr, motor_rl, motor_rr;
	logic mix_valid;

	int fd;
	int status;
	int fields;
	int vectors;
	logic [1023:0] line_buf;

	// Fields of one vector line
	logic [31:0] cycles, throttle_v;
	logic [31:0] yaw_t_v, roll_t_v, pitch_t_v;
	logic [31:0] yaw_r_v, roll_r_v, pitch_r_v;
	logic [31:0] exp_fl, exp_fr, exp_rl, exp_rr;

	flight_control_core dut_i (
		.motor_fl(motor_fl),
		.motor_fr(motor_fr),
		.motor_rl(motor_rl),
		.motor_rr(motor_rr),
		.mix_valid(mix_valid),
		.throttle_cmd(throttle_cmd),
		.yaw_target(yaw_target),
		.roll_target(roll_target),
		.pitch_target(pitch_target),
		.yaw_rotation(yaw_rotation),
		.roll_rotation(roll_rotation),
		.pitch_rotation(pitch_rotation),
		.start_signal(start_signal),
		.resetn(resetn),
		.us_clk(us_clk)
	);

	initial begin
		us_clk = 1'b0;
		forever #(CLK_PERIOD / 2) us_clk = ~us_clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("Verification failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// Sampled on falling edges, where mix_valid is stable
	task automatic wait_for_mix();
		int waited;
		waited = 0;
		while (mix_valid !== 1'b1) begin
			if (waited == MIX_TIMEOUT)
				abort_run($sformatf("mix_valid never rose within %0d cycles", MIX_TIMEOUT));
			@(negedge us_clk);
			waited++;
		end
	endtask

	// Runs the vector's inputs for each of its control cycles, then checks the motors
	task automatic run_vector();
		int n;
		for (n = 0; n < int'(cycles); n++) begin
			@(negedge us_clk);
			throttle_cmd = throttle_v[11:0];
			yaw_target = yaw_t_v[15:0];
			roll_target = roll_t_v[15:0];
			pitch_target = pitch_t_v[15:0];
			yaw_rotation = yaw_r_v[15:0];
			roll_rotation = roll_r_v[15:0];
			pitch_rotation = pitch_r_v[15:0];
			start_signal = 1'b1;
			@(negedge us_clk);
			start_signal = 1'b0;
			wait_for_mix();
		end
		check_value($sformatf("motor_fl (vector %0d)", vectors + 1), 32'(motor_fl), exp_fl);
		check_value($sformatf("motor_fr (vector %0d)", vectors + 1), 32'(motor_fr), exp_fr);
		check_value($sformatf("motor_rl (vector %0d)", vectors + 1), 32'(motor_rl), exp_rl);
		check_value($sformatf("motor_rr (vector %0d)", vectors + 1), 32'(motor_rr), exp_rr);
		// mix_valid is a single-cycle pulse
		@(negedge us_clk);
		check_value("mix_valid", 32'(mix_valid), 32'h0);
	endtask

	initial begin
		resetn = 1'b0;
		start_signal = 1'b0;
		throttle_cmd = '0;
		yaw_target = '0;
		roll_target = '0;
		pitch_target = '0;
		yaw_rotation = '0;
		roll_rotation = '0;
		pitch_rotation = '0;
		vectors = 0;

		repeat (2) @(negedge us_clk);
		resetn = 1'b1;

		// Idle outputs after reset
		@(negedge us_clk);
		check_value("motor_fl", 32'(motor_fl), 32'h0);
		check_value("motor_fr", 32'(motor_fr), 32'h0);
		check_value("motor_rl", 32'(motor_rl), 32'h0);
		check_value("motor_rr", 32'(motor_rr), 32'h0);
		check_value("mix_valid", 32'(mix_valid), 32'h0);

		fd = $fopen("verif/flight_tests.txt", "r");
		if (fd == 0)
			abort_run("could not open verif/flight_tests.txt");

		// Comment and blank lines scan no fields and are skipped
		while (!$feof(fd)) begin
			line_buf = '0;
			status = $fgets(line_buf, fd);
			if (status == 0)
				fields = 0;
			else
				fields = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h %h %h %h",
					cycles, throttle_v, yaw_t_v, roll_t_v, pitch_t_v,
					yaw_r_v, roll_r_v, pitch_r_v, exp_fl, exp_fr, exp_rl, exp_rr);
			if (fields == 12) begin
				run_vector();
				vectors++;
			end else if (fields > 0) begin
				abort_run($sformatf("malformed vector line after vector %0d", vectors));
			end
		end
		$fclose(fd);

		if (vectors == 0) begin
			abort_run("no test vectors found in verif/flight_tests.txt");
		end else begin
			$display("%0d vectors checked", vectors);
			$display("Verification passed");
			$finish;
		end
	end

endmodule

//--- hdl/flight_control_core.sv
/* Flight control core on a 1 MHz us_clk. Hold start_signal low until
   mix_valid before starting the next cycle. */
`timescale 1ns/1ns

module flight_control_core (
	output flight_pkg::motor_t motor_fl,
	output flight_pkg::motor_t motor_fr,
	output flight_pkg::motor_t motor_rl,
	output flight_pkg::motor_t motor_rr,
	output logic mix_valid,
	input flight_pkg::throttle_t throttle_cmd,
	input flight_pkg::rate_t yaw_target,
	input flight_pkg::rate_t roll_target,
	input flight_pkg::rate_t pitch_target,
	input flight_pkg::rate_t yaw_rotation,
	input flight_pkg::rate_t roll_rotation,
	input flight_pkg::rate_t pitch_rotation,
	input logic start_signal,
	input logic resetn,
	input logic us_clk
);

	flight_pkg::rate_t yaw_rate, roll_rate, pitch_rate;
	flight_pkg::throttle_t throttle_out;
	logic rates_done;
	logic throttle_done;

	body_frame_controller bfc_i (
		.yaw_rate_out(yaw_rate),
		.roll_rate_out(roll_rate),
		.pitch_rate_out(pitch_rate),
		.complete_signal(rates_done),
		.yaw_target(yaw_target),
		.roll_target(roll_target),
		.pitch_target(pitch_target),
		.yaw_rotation(yaw_rotation),
		.roll_rotation(roll_rotation),
		.pitch_rotation(pitch_rotation),
		.start_signal(start_signal),
		.resetn(resetn),
		.us_clk(us_clk)
	);

	throttle_ramp ramp_i (
		.throttle_out(throttle_out),
		.throttle_done(throttle_done),
		.throttle_cmd(throttle_cmd),
		.start_signal(start_signal),
		.resetn(resetn),
		.us_clk(us_clk)
	);

	motor_mixer mixer_i (
		.motor_fl(motor_fl),
		.motor_fr(motor_fr),
		.motor_rl(motor_rl),
		.motor_rr(motor_rr),
		.mix_valid(mix_valid),
		.yaw_rate(yaw_rate),
		.roll_rate(roll_rate),
		.pitch_rate(pitch_rate),
		.rates_done(rates_done),
		.throttle_out(throttle_out),
		.throttle_done(throttle_done),
		.resetn(resetn),
		.us_clk(us_clk)
	);

endmodule

//--- hdl/motor_mixer.sv
/* Quad-X mixer. Waits for both rate and throttle results, then registers
   four commands clamped to 0..MOTOR_MAX with a one-cycle mix_valid. */
`timescale 1ns/1ns

module motor_mixer (
	output flight_pkg::motor_t motor_fl,
	output flight_pkg::motor_t motor_fr,
	output flight_pkg::motor_t motor_rl,
	output flight_pkg::motor_t motor_rr,
	output logic mix_valid,
	input flight_pkg::rate_t yaw_rate,
	input flight_pkg::rate_t roll_rate,
	input flight_pkg::rate_t pitch_rate,
	input logic rates_done,
	input flight_pkg::throttle_t throttle_out,
	input logic throttle_done,
	input logic resetn,
	input logic us_clk
);

	logic rates_pending;
	logic throttle_pending;
	logic both_ready;
	int t, r, p, y;

	function automatic flight_pkg::motor_t clamp_motor(input int value);
		if (value < 0)
			return '0;
		else if (value > flight_pkg::MOTOR_MAX)
			return flight_pkg::motor_t'(flight_pkg::MOTOR_MAX);
		else
			return flight_pkg::motor_t'(value);
	endfunction

	// A done pulse counts in its own cycle, so mix_valid follows the later one
	assign both_ready = (rates_pending || rates_done) && (throttle_pending || throttle_done);

	// Rates down to whole deg/s
	always_comb begin
		t = int'(throttle_out);
		r = int'(roll_rate) >>> flight_pkg::FIXED_POINT_SHIFT;
		p = int'(pitch_rate) >>> flight_pkg::FIXED_POINT_SHIFT;
		y = int'(yaw_rate) >>> flight_pkg::FIXED_POINT_SHIFT;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			rates_pending <= 1'b0;
			throttle_pending <= 1'b0;
			mix_valid <= 1'b0;
			motor_fl <= '0;
			motor_fr <= '0;
			motor_rl <= '0;
			motor_rr <= '0;
		end else begin
			mix_valid <= both_ready;
			if (both_ready) begin
				rates_pending <= 1'b0;
				throttle_pending <= 1'b0;
				motor_fl <= clamp_motor(t + p + r - y);
				motor_fr <= clamp_motor(t + p - r + y);
				motor_rl <= clamp_motor(t - p + r + y);
				motor_rr <= clamp_motor(t - p - r - y);
			end else begin
				if (rates_done)
					rates_pending <= 1'b1;
				if (throttle_done)
					throttle_pending <= 1'b1;
			end
		end
	end

endmodule

//--- hdl/throttle_ramp.sv
/* Throttle slew limiter, at most THROTTLE_STEP per start edge. */
`timescale 1ns/1ns

module throttle_ramp (
	output flight_pkg::throttle_t throttle_out,
	output logic throttle_done,
	input flight_pkg::throttle_t throttle_cmd,
	input logic start_signal,
	input logic resetn,
	input logic us_clk
);

	logic start_flag;
	logic start_edge;
	logic going_up;
	flight_pkg::throttle_t gap;
	flight_pkg::throttle_t step;
	flight_pkg::throttle_t throttle_next;

	assign start_edge = start_signal && !start_flag;

	always_comb begin
		going_up = (throttle_cmd >= throttle_out);
		gap = going_up ? throttle_cmd - throttle_out : throttle_out - throttle_cmd;
		// Smaller of gap and step, so the command is hit exactly
		step = (gap > flight_pkg::THROTTLE_STEP) ?
			flight_pkg::throttle_t'(flight_pkg::THROTTLE_STEP) : gap;
		throttle_next = going_up ? throttle_out + step : throttle_out - step;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			start_flag <= 1'b0;
			throttle_out <= '0;
			throttle_done <= 1'b0;
		end else begin
			start_flag <= start_signal;
			throttle_done <= start_edge;
			if (start_edge)
				throttle_out <= throttle_next;
		end
	end

endmodule

//--- hdl/body_frame_controller.sv
/* Three-axis body rate controller. IMU rates arrive in 12.4 like the targets;
   yaw and pitch rotation are negated on latch to match the IMU mounting. */
`timescale 1ns/1ns

module body_frame_controller (
	output flight_pkg::rate_t yaw_rate_out,
	output flight_pkg::rate_t roll_rate_out,
	output flight_pkg::rate_t pitch_rate_out,
	output logic complete_signal,
	input flight_pkg::rate_t yaw_target,
	input flight_pkg::rate_t roll_target,
	input flight_pkg::rate_t pitch_target,
	input flight_pkg::rate_t yaw_rotation,
	input flight_pkg::rate_t roll_rotation,
	input flight_pkg::rate_t pitch_rotation,
	input logic start_signal,
	input logic resetn,
	input logic us_clk
);

	logic start_flag;
	logic start_edge;
	logic start_pulse;
	logic wait_flag;
	logic yaw_active, roll_active, pitch_active;
	logic yaw_complete, roll_complete, pitch_complete;
	flight_pkg::rate_t latched_yaw_target, latched_roll_target, latched_pitch_target;
	flight_pkg::rate_t latched_yaw_rotation, latched_roll_rotation, latched_pitch_rotation;
	flight_pkg::bfc_state_t state, next_state;

	assign start_edge = start_signal && !start_flag;

	// start_pulse marks the one cycle after the edge, with the inputs latched
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			start_flag <= 1'b0;
			start_pulse <= 1'b0;
		end else begin
			start_flag <= start_signal;
			start_pulse <= start_edge;
		end
	end

	always_ff @(posedge us_clk) begin
		if (start_edge) begin
			latched_yaw_target <= yaw_target;
			latched_roll_target <= roll_target;
			latched_pitch_target <= pitch_target;
			latched_yaw_rotation <= -yaw_rotation;
			latched_roll_rotation <= roll_rotation;
			latched_pitch_rotation <= -pitch_rotation;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			state <= flight_pkg::WAITING;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			flight_pkg::WAITING:
				if (start_pulse)
					next_state = flight_pkg::STARTING;
			flight_pkg::STARTING:
				if (yaw_active && roll_active && pitch_active)
					next_state = flight_pkg::ACTIVE;
			flight_pkg::ACTIVE:
				if (yaw_complete && roll_complete && pitch_complete)
					next_state = flight_pkg::COMPLETE;
			flight_pkg::COMPLETE:
				next_state = flight_pkg::WAITING;
			default:
				next_state = flight_pkg::WAITING;
		endcase
	end

	assign wait_flag = (state == flight_pkg::WAITING);
	assign complete_signal = (state == flight_pkg::COMPLETE);

	pid #(
		.K_P(flight_pkg::YAW_K_P),
		.K_P_SHIFT(flight_pkg::YAW_K_P_SHIFT),
		.K_I_SHIFT(flight_pkg::YAW_K_I_SHIFT)
	) yaw_pid (
		.rate_out(yaw_rate_out),
		.pid_active(yaw_active),
		.pid_complete(yaw_complete),
		.target_rotation(latched_yaw_target),
		.actual_rotation(latched_yaw_rotation),
		.start_flag(start_pulse),
		.wait_flag(wait_flag),
		.resetn(resetn),
		.us_clk(us_clk)
	);

	pid #(
		.K_P(flight_pkg::ROLL_K_P),
		.K_P_SHIFT(flight_pkg::ROLL_K_P_SHIFT),
		.K_I_SHIFT(flight_pkg::ROLL_K_I_SHIFT)
	) roll_pid (
		.rate_out(roll_rate_out),
		.pid_active(roll_active),
		.pid_complete(roll_complete),
		.target_rotation(latched_roll_target),
		.actual_rotation(latched_roll_rotation),
		.start_flag(start_pulse),
		.wait_flag(wait_flag),
		.resetn(resetn),
		.us_clk(us_clk)
	);

	pid #(
		.K_P(flight_pkg::PITCH_K_P),
		.K_P_SHIFT(flight_pkg::PITCH_K_P_SHIFT),
		.K_I_SHIFT(flight_pkg::PITCH_K_I_SHIFT)
	) pitch_pid (
		.rate_out(pitch_rate_out),
		.pid_active(pitch_active),
		.pid_complete(pitch_complete),
		.target_rotation(latched_pitch_target),
		.actual_rotation(latched_pitch_rotation),
		.start_flag(start_pulse),
		.wait_flag(wait_flag),
		.resetn(resetn),
		.us_clk(us_clk)
	);

endmodule

//--- hdl/pid.sv
/* Single-axis PI rate controller, 3 cycles from start_flag to rate_out.
   The integrator is cleared only by resetn and carries over between cycles. */
`timescale 1ns/1ns

module pid #(
	parameter int K_P = 1,
	parameter int K_P_SHIFT = 0,
	parameter int K_I_SHIFT = 0
) (
	output flight_pkg::rate_t rate_out,
	output logic pid_active,
	output logic pid_complete,
	input flight_pkg::rate_t target_rotation,
	input flight_pkg::rate_t actual_rotation,
	input logic start_flag,
	input logic wait_flag,
	input logic resetn,
	input logic us_clk
);

	logic signed [16:0] diff;
	flight_pkg::rate_t error_sat;
	flight_pkg::rate_t error_reg;
	logic signed [20:0] integ_sum;
	flight_pkg::integ_t integ_next;
	flight_pkg::integ_t integ;
	int p_term;
	int i_term;
	int out_sum;
	flight_pkg::rate_t out_next;
	logic start_now;
	logic integ_step;
	logic out_step;

	// Only accept a start while idle
	assign start_now = start_flag && !pid_active && !pid_complete;

	// Error saturated back to 16 bits
	always_comb begin
		diff = 17'(target_rotation) - 17'(actual_rotation);
		if (diff[16] != diff[15])
			error_sat = diff[16] ? 16'sh8000 : 16'sh7fff;
		else
			error_sat = diff[15:0];
	end

	always_comb begin
		integ_sum = 21'(integ) + 21'(error_reg);
		if (integ_sum > flight_pkg::INTEG_LIMIT)
			integ_next = flight_pkg::integ_t'(flight_pkg::INTEG_LIMIT);
		else if (integ_sum < -flight_pkg::INTEG_LIMIT)
			integ_next = flight_pkg::integ_t'(-flight_pkg::INTEG_LIMIT);
		else
			integ_next = integ_sum[19:0];
	end

	// P and I terms on the already updated integrator
	always_comb begin
		p_term = (32'(error_reg) * K_P) >>> K_P_SHIFT;
		i_term = 32'(integ) >>> K_I_SHIFT;
		out_sum = p_term + i_term;
		if (out_sum > flight_pkg::RATE_LIMIT)
			out_next = flight_pkg::rate_t'(flight_pkg::RATE_LIMIT);
		else if (out_sum < -flight_pkg::RATE_LIMIT)
			out_next = flight_pkg::rate_t'(-flight_pkg::RATE_LIMIT);
		else
			out_next = out_sum[15:0];
	end

	always_ff @(posedge us_clk) begin
		if (start_now)
			error_reg <= error_sat;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			pid_active <= 1'b0;
			pid_complete <= 1'b0;
			integ_step <= 1'b0;
			out_step <= 1'b0;
			integ <= '0;
			rate_out <= '0;
		end else begin
			integ_step <= start_now;
			out_step <= integ_step;
			if (start_now)
				pid_active <= 1'b1;
			else if (out_step)
				pid_active <= 1'b0;
			if (integ_step)
				integ <= integ_next;
			// Complete holds until the controller goes back to waiting
			if (out_step) begin
				rate_out <= out_next;
				pid_complete <= 1'b1;
			end else if (wait_flag) begin
				pid_complete <= 1'b0;
			end
		end
	end

endmodule

//--- hdl/flight_pkg.sv
/* Shared fixed-point types, limits and per-axis gains for the flight core.
   Rates are signed 12.4 deg/s; throttle and motor commands are unsigned 12-bit. */

package flight_pkg;

	// Signed 12.4 rate in deg/s
	typedef logic signed [15:0] rate_t;

	// Integrator accumulator, wide enough for INTEG_LIMIT plus one error
	typedef logic signed [19:0] integ_t;

	typedef logic [11:0] throttle_t;
	typedef logic [11:0] motor_t;

	localparam int FIXED_POINT_SHIFT = 4;

	// 250 deg/s in 12.4
	localparam int RATE_LIMIT = 250 << FIXED_POINT_SHIFT;
	localparam int INTEG_LIMIT = 65536;
	localparam int MOTOR_MAX = 4095;

	// Largest throttle change per control cycle
	localparam int THROTTLE_STEP = 64;

	// Yaw gains
	localparam int YAW_K_P = 3;
	localparam int YAW_K_P_SHIFT = 2;
	localparam int YAW_K_I_SHIFT = 6;

	// Roll gains
	localparam int ROLL_K_P = 5;
	localparam int ROLL_K_P_SHIFT = 2;
	localparam int ROLL_K_I_SHIFT = 5;

	// Pitch gains, same as roll on a symmetric frame
	localparam int PITCH_K_P = 5;
	localparam int PITCH_K_P_SHIFT = 2;
	localparam int PITCH_K_I_SHIFT = 5;

	// One-hot controller states
	typedef enum logic [3:0] {
		WAITING  = 4'b0001,
		STARTING = 4'b0010,
		ACTIVE   = 4'b0100,
		COMPLETE = 4'b1000
	} bfc_state_t;

endpackage
